// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int unsigned xlen = 32;                  // data and address width
    localparam logic [xlen-1:0] reset_vector = 32'h0;   // first fetch after reset
    localparam logic [xlen-1:0] pc_step = 32'd4;        // one 32-bit word per fetch
    localparam logic [xlen-1:0] nop_instr = 32'h00000013; // addi x0,x0,0

    // fetch FSM, same roles as the memory fetch block it grew from
    typedef enum logic [1:0] {
        fs_idle         = 2'b00, // free, may issue a request
        fs_wait_gnt     = 2'b01, // req held, memory has not taken it yet
        fs_wait_rvalid  = 2'b10, // granted, word still to come
        fs_abort_rvalid = 2'b11  // granted but aborted, word gets dropped
    } fetch_state_e;

    // rv32i major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_other  = 7'b0000000  // anything not listed above
    } opcode_e;

    // read-only instruction memory port
    typedef struct packed {
        logic            req;
        logic [xlen-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic            gnt;
        logic            rvalid; // one per grant, at least a cycle later
        logic [xlen-1:0] rdata;
    } mem_rsp_t;

    // fetched word tagged with its address
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr; // nop_instr while valid is low
    } fetch_out_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        opcode_e         opcode;
        logic            is_jal;
        logic [xlen-1:0] target; // pc + j immediate, only meaningful on jal
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== logic/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// fetch front end: pc generator, fetch unit, predecoder
module fetch_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,   // execute stall, holds the whole front end
    output fetch_pkg::mem_req_t     mem_req_o,
    input  fetch_pkg::mem_rsp_t     mem_rsp_i,
    output fetch_pkg::decoded_t     decoded_o
);

    logic [fetch_pkg::xlen-1:0] pc;
    logic                       pc_valid;
    logic                       next_ready;  // grant seen, pc may step
    fetch_pkg::redirect_t       redirect;    // jal from predecode
    fetch_pkg::fetch_out_t      fetch;

    pc_gen u_pc_gen (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .next_ready_i (next_ready),
        .redirect_i   (redirect),
        .pc_o         (pc),
        .pc_valid_o   (pc_valid)
    );

    ins_fetch u_ins_fetch (
        .clk          (clk),
        .reset        (reset),
        .pc_i         (pc),
        .pc_valid_i   (pc_valid),
        .stall_i      (stall_i),
        .redirect_i   (redirect),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .next_ready_o (next_ready),
        .fetch_o      (fetch)
    );

    ins_predecode u_ins_predecode (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .fetch_i      (fetch),
        .redirect_o   (redirect),
        .decoded_o    (decoded_o)
    );

endmodule

`default_nettype wire

// ==== logic/ins_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

// instruction fetch on the req/gnt/rvalid port
// one read outstanding at most, nop while nothing is ready,
// one backup entry for a word that lands while execute is stalled
module ins_fetch (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [fetch_pkg::xlen-1:0]     pc_i,
    input  logic                           pc_valid_i,
    input  logic                           stall_i,
    input  fetch_pkg::redirect_t           redirect_i,  // acts as abort
    output fetch_pkg::mem_req_t            mem_req_o,
    input  fetch_pkg::mem_rsp_t            mem_rsp_i,
    output logic                           next_ready_o,
    output fetch_pkg::fetch_out_t          fetch_o
);

    fetch_pkg::fetch_state_e state_q, state_d;

    logic                       accept;    // pc side wants a fetch and may have one
    logic                       slot_free; // nothing outstanding after this cycle
    logic                       issue;     // fresh request this cycle
    logic                       req;
    logic                       mem_word;  // live word from memory
    logic                       deliver_mem;
    logic                       deliver_bk;

    logic [fetch_pkg::xlen-1:0] req_pc_q;  // address of the granted request

    // backup entry, filled when rvalid meets a stall
    logic                       bk_valid_q;
    logic [fetch_pkg::xlen-1:0] bk_pc_q;
    logic [fetch_pkg::xlen-1:0] bk_instr_q;

    // a jal in flight blocks its sequential successor
    assign accept = pc_valid_i & ~stall_i & ~redirect_i.valid;

    always_comb begin
        state_d   = state_q;
        slot_free = 1'b0;
        case (state_q)
            fetch_pkg::fs_idle: begin
                slot_free = 1'b1;
            end
            fetch_pkg::fs_wait_gnt: begin
                // req stays up until taken, stall or not
                if (mem_rsp_i.gnt) begin
                    state_d = redirect_i.valid ? fetch_pkg::fs_abort_rvalid
                                               : fetch_pkg::fs_wait_rvalid;
                end
            end
            fetch_pkg::fs_wait_rvalid: begin
                if (mem_rsp_i.rvalid) begin
                    slot_free = 1'b1;             // word handed out or backed up
                    state_d   = fetch_pkg::fs_idle;
                end else if (redirect_i.valid) begin
                    state_d = fetch_pkg::fs_abort_rvalid; // word now stale
                end
            end
            fetch_pkg::fs_abort_rvalid: begin
                // drop the stale word, even if it lands under stall
                if (mem_rsp_i.rvalid) begin
                    slot_free = 1'b1;
                    state_d   = fetch_pkg::fs_idle;
                end
            end
            default: begin
                state_d = fetch_pkg::fs_idle;
            end
        endcase

        // back-to-back: next request may go out with the rvalid
        if (slot_free && accept) begin
            state_d = mem_rsp_i.gnt ? fetch_pkg::fs_wait_rvalid : fetch_pkg::fs_wait_gnt;
        end
    end

    assign issue = slot_free & accept;
    assign req   = issue | (state_q == fetch_pkg::fs_wait_gnt);

    always_comb begin
        mem_req_o.req  = req;
        mem_req_o.addr = req ? pc_i : '0; // pc_i holds still until the grant
    end

    assign next_ready_o = req & mem_rsp_i.gnt; // pc_gen steps on this

    // word delivery
    assign mem_word    = (state_q == fetch_pkg::fs_wait_rvalid) & mem_rsp_i.rvalid;
    assign deliver_mem = mem_word & ~stall_i;
    assign deliver_bk  = bk_valid_q & ~stall_i; // first cycle after stall drops

    always_comb begin
        fetch_o.valid = deliver_mem | deliver_bk;
        fetch_o.pc    = bk_valid_q ? bk_pc_q : req_pc_q;
        fetch_o.instr = fetch_pkg::nop_instr; // bubble
        if (deliver_bk) begin
            fetch_o.instr = bk_instr_q;
        end else if (deliver_mem) begin
            fetch_o.instr = mem_rsp_i.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= fetch_pkg::fs_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // tag for the returning word, updated at the grant edge
    always_ff @(posedge clk) begin
        if (next_ready_o) begin
            req_pc_q <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bk_valid_q <= 1'b0;
        end else if (mem_word && stall_i) begin
            bk_valid_q <= 1'b1;          // execute busy, park the word
        end else if (deliver_bk) begin
            bk_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_word && stall_i) begin
            bk_pc_q    <= req_pc_q;
            bk_instr_q <= mem_rsp_i.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ins_predecode.sv ====
`timescale 1ns/10ps
`default_nettype none

// predecoder behind the fetch unit
// classifies the opcode, resolves jal and registers the result
module ins_predecode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  fetch_pkg::fetch_out_t   fetch_i,
    output fetch_pkg::redirect_t    redirect_o,
    output fetch_pkg::decoded_t     decoded_o
);

    fetch_pkg::opcode_e         opcode;
    logic                       is_jal;
    logic [fetch_pkg::xlen-1:0] j_imm;
    logic [fetch_pkg::xlen-1:0] jal_target;
    fetch_pkg::decoded_t        dec_d;
    fetch_pkg::decoded_t        dec_q;

    // opcode class, unknown patterns fold into op_other
    always_comb begin
        case (fetch_i.instr[6:0])
            fetch_pkg::op_lui:    opcode = fetch_pkg::op_lui;
            fetch_pkg::op_auipc:  opcode = fetch_pkg::op_auipc;
            fetch_pkg::op_jal:    opcode = fetch_pkg::op_jal;
            fetch_pkg::op_jalr:   opcode = fetch_pkg::op_jalr;
            fetch_pkg::op_branch: opcode = fetch_pkg::op_branch;
            fetch_pkg::op_load:   opcode = fetch_pkg::op_load;
            fetch_pkg::op_store:  opcode = fetch_pkg::op_store;
            fetch_pkg::op_imm:    opcode = fetch_pkg::op_imm;
            fetch_pkg::op_reg:    opcode = fetch_pkg::op_reg;
            default:              opcode = fetch_pkg::op_other;
        endcase
    end

    assign is_jal = (opcode == fetch_pkg::op_jal);

    // j-type immediate, imm[20|10:1|11|19:12] scattered over instr[31:12]
    assign j_imm = {{12{fetch_i.instr[31]}},
                    fetch_i.instr[19:12],
                    fetch_i.instr[20],
                    fetch_i.instr[30:21],
                    1'b0};

    assign jal_target = fetch_i.pc + j_imm;

    // same cycle as the word, so the successor request never goes out
    always_comb begin
        redirect_o.valid  = fetch_i.valid & is_jal;
        redirect_o.target = jal_target;
    end

    always_comb begin
        dec_d.valid  = fetch_i.valid;
        dec_d.pc     = fetch_i.pc;
        dec_d.instr  = fetch_i.instr; // already nop when invalid
        dec_d.opcode = opcode;
        dec_d.is_jal = is_jal;
        dec_d.target = jal_target;
    end

    // one stage, frozen while execute stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_q.valid <= 1'b0;
        end else if (!stall_i) begin
            dec_q <= dec_d;
        end
    end

    assign decoded_o = dec_q;

endmodule

`default_nettype wire

// ==== logic/pc_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// program counter for the fetch unit
// steps on every grant, jumps on a redirect
module pc_gen (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall_i,      // execute stall
    input  logic                           next_ready_i, // request granted this cycle
    input  fetch_pkg::redirect_t           redirect_i,
    output logic [fetch_pkg::xlen-1:0]     pc_o,
    output logic                           pc_valid_o
);

    logic [fetch_pkg::xlen-1:0] pc_q;
    logic                       run_q; // low only in the first cycle out of reset

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q  <= fetch_pkg::reset_vector;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            // redirect wins over the sequential step
            if (redirect_i.valid) begin
                pc_q <= redirect_i.target;
            end else if (next_ready_i) begin
                pc_q <= pc_q + fetch_pkg::pc_step; // a grant may land under stall too
            end
        end
    end

    assign pc_o = pc_q;

    // no new fetch under stall or while the pc is being reloaded
    assign pc_valid_o = run_q & ~stall_i & ~redirect_i.valid;

endmodule

`default_nettype wire

// ==== project.f ====
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/ins_fetch.sv
logic/ins_predecode.sv
logic/fetch_top.sv
test/fetch_assert.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fetch_tb -f project.f -o fetch_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/fetch_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/fetch_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

// protocol checks on the fetch unit, bound into ins_fetch
module fetch_assert (
    input logic                    clk,
    input logic                    reset,
    input fetch_pkg::fetch_state_e state_i,
    input fetch_pkg::mem_req_t     mem_req_i,
    input fetch_pkg::mem_rsp_t     mem_rsp_i,
    input fetch_pkg::fetch_out_t   fetch_i
);

    int unsigned fail_count = 0;  // picked up by the testbench at the end
    logic        outstanding_q;   // granted on the bus, rvalid not seen yet

    // tracked from bus events only, independent of the fsm
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_i.req && mem_rsp_i.gnt) begin
            outstanding_q <= 1'b1;  // back to back grant keeps it set
        end else if (mem_rsp_i.rvalid) begin
            outstanding_q <= 1'b0;
        end
    end

    // ungranted request stays up with the same address
    req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req_i.req && !mem_rsp_i.gnt |=> mem_req_i.req && $stable(mem_req_i.addr))
        else begin
            fail_count++;
            $error("request dropped or address changed before grant");
        end

    // one read in flight, no new request before the rvalid
    one_outstanding: assert property (@(posedge clk) disable iff (reset)
        outstanding_q && !mem_rsp_i.rvalid |->
            !mem_req_i.req && (state_i == fetch_pkg::fs_wait_rvalid ||
                               state_i == fetch_pkg::fs_abort_rvalid))
        else begin
            fail_count++;
            $error("new request or wrong fetch state while a response is outstanding");
        end

    nop_when_idle: assert property (@(posedge clk) disable iff (reset)
        !fetch_i.valid |-> fetch_i.instr == fetch_pkg::nop_instr)
        else begin
            fail_count++;
            $error("fetch output carries a non-nop word while invalid");
        end

endmodule

bind ins_fetch fetch_assert u_fetch_assert (
    .clk       (clk),
    .reset     (reset),
    .state_i   (state_q),
    .mem_req_i (mem_req_o),
    .mem_rsp_i (mem_rsp_i),
    .fetch_i   (fetch_o)
);

`default_nettype wire

// ==== test/fetch_stim.txt ====
# M addr word (hex) memory image, S cycle length (decimal) stall window after reset
# E pc instr (hex) expected retire order
M 00000000 123450b7
M 00000004 00000117
M 00000008 00500193
M 0000000c 00208233
M 00000010 0000a283
M 00000014 0050a223
M 00000018 00208463
M 0000001c 0240006f
M 00000020 00100313
M 00000030 00800413
M 00000034 00900493
M 00000038 40208533
M 0000003c 0440006f
M 00000040 00008067
M 00000044 0000000b
M 00000048 fe9ff0ef
M 00000080 000015b7
M 00000084 fff58613
S 5 4
S 18 6
S 40 5
E 00000000 123450b7
E 00000004 00000117
E 00000008 00500193
E 0000000c 00208233
E 00000010 0000a283
E 00000014 0050a223
E 00000018 00208463
E 0000001c 0240006f
E 00000040 00008067
E 00000044 0000000b
E 00000048 fe9ff0ef
E 00000030 00800413
E 00000034 00900493
E 00000038 40208533
E 0000003c 0440006f
E 00000080 000015b7
E 00000084 fff58613

// ==== test/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

// testbench for the fetch front end
// memory image, stall windows and retire order come from test/fetch_stim.txt
module fetch_tb;

    localparam int clk_period = 100;
    localparam int reset_cycles = 5;
    localparam int cycles_per_instr = 40;  // watchdog budget per expected word

    logic                clk;
    logic                reset = 1'b1;
    logic                stall = 1'b0;
    fetch_pkg::mem_req_t mem_req;
    fetch_pkg::mem_rsp_t mem_rsp = '0;
    fetch_pkg::decoded_t decoded;

    logic [31:0] mem_image [logic [31:0]];  // sparse instruction memory
    int unsigned stall_from[$];
    int unsigned stall_len[$];
    logic [31:0] exp_pc[$];
    logic [31:0] exp_instr[$];
    int unsigned stall_total = 0;
    logic        loaded = 1'b0;

    int          seed = 32'h21d0a293;
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned retired = 0;
    int unsigned cycle = 0;     // counted from reset release

    // memory model state, updated mid-cycle
    logic                pending = 1'b0;
    logic [31:0]         pend_addr;
    int unsigned         rv_left = 0;   // cycles until rvalid
    int unsigned         gnt_left = 0;  // req cycles until gnt
    fetch_pkg::mem_rsp_t rsp_next = '0;

    // retire monitor state
    fetch_pkg::decoded_t prev_dec;
    logic                stall_seen = 1'b0;  // stall as seen by the last rising edge
    logic                jump_pending = 1'b0;
    logic [31:0]         jump_to;

    fetch_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .stall_i   (stall),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp),
        .decoded_o (decoded)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    // unlisted words get an address-dependent filler
    function automatic logic [31:0] read_mem(input logic [31:0] addr);
        if (mem_image.exists(addr)) begin
            return mem_image[addr];
        end
        return {addr[15:0], ~addr[31:16]};
    endfunction

    // major opcode classes of rv32i
    function automatic fetch_pkg::opcode_e class_of(input logic [31:0] instr);
        case (instr[6:0])
            7'h37:   return fetch_pkg::op_lui;
            7'h17:   return fetch_pkg::op_auipc;
            7'h6f:   return fetch_pkg::op_jal;
            7'h67:   return fetch_pkg::op_jalr;
            7'h63:   return fetch_pkg::op_branch;
            7'h03:   return fetch_pkg::op_load;
            7'h23:   return fetch_pkg::op_store;
            7'h13:   return fetch_pkg::op_imm;
            7'h33:   return fetch_pkg::op_reg;
            default: return fetch_pkg::op_other;
        endcase
    endfunction

    function automatic logic [31:0] jal_dest(input logic [31:0] pc, input logic [31:0] instr);
        logic [20:0] imm;
        imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};  // j-type layout
        return pc + {{11{imm[20]}}, imm};
    endfunction

    function automatic logic in_window(input int unsigned c);
        foreach (stall_from[i]) begin
            if (c >= stall_from[i] && c < stall_from[i] + stall_len[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic load_stim();
        int          fd;
        int          code;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("test/fetch_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open test/fetch_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0) begin
                if (line[0] == "M" && $sscanf(line, "M %h %h", a, b) == 2) begin
                    mem_image[a] = b;
                end else if (line[0] == "S" && $sscanf(line, "S %d %d", a, b) == 2) begin
                    stall_from.push_back(a);
                    stall_len.push_back(b);
                    stall_total += b;
                end else if (line[0] == "E" && $sscanf(line, "E %h %h", a, b) == 2) begin
                    exp_pc.push_back(a);
                    exp_instr.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    // one retired word against the next expected entry
    task automatic check_retire();
        logic [31:0]        pc_x;
        logic [31:0]        in_x;
        fetch_pkg::opcode_e op_x;
        if (retired >= exp_pc.size()) begin
            return;  // past the end of the list
        end
        pc_x = exp_pc[retired];
        in_x = exp_instr[retired];
        op_x = class_of(in_x);
        checks++;
        assert (decoded.pc == pc_x && decoded.instr == in_x) else begin
            errors++;
            $display("[FAIL] %0t retire %0d: pc %h instr %h, expected pc %h instr %h",
                     $time, retired, decoded.pc, decoded.instr, pc_x, in_x);
        end
        assert (decoded.opcode == op_x && decoded.is_jal == (op_x == fetch_pkg::op_jal)) else begin
            errors++;
            $display("[FAIL] %0t pc %h: opcode %h, expected %h", $time, pc_x,
                     decoded.opcode, op_x);
        end
        if (op_x == fetch_pkg::op_jal) begin
            assert (decoded.target == jal_dest(pc_x, in_x)) else begin
                errors++;
                $display("[FAIL] %0t jal at %h: target %h, expected %h", $time, pc_x,
                         decoded.target, jal_dest(pc_x, in_x));
            end
        end
        if (jump_pending) begin
            assert (decoded.pc == jump_to) else begin
                errors++;
                $display("[FAIL] %0t word after jal at pc %h, expected %h", $time,
                         decoded.pc, jump_to);
            end
        end
        jump_pending = (op_x == fetch_pkg::op_jal);
        jump_to      = jal_dest(pc_x, in_x);
        retired++;
    endtask

    // memory: gnt after 0..2 req cycles, rvalid 1..3 cycles after the grant
    always @(negedge clk) begin
        if (reset) begin
            pending  = 1'b0;
            gnt_left = rand_below(3);
            rsp_next = '0;
        end else begin
            if (mem_rsp.rvalid) begin
                pending = 1'b0;
            end
            if (mem_req.req && mem_rsp.gnt) begin
                pending   = 1'b1;
                pend_addr = mem_req.addr;
                rv_left   = 1 + rand_below(3);
                gnt_left  = rand_below(3);
            end else if (mem_req.req && gnt_left > 0) begin
                gnt_left--;
            end
            rsp_next = '0;
            if (pending) begin
                rv_left--;
                if (rv_left == 0) begin
                    rsp_next.rvalid = 1'b1;
                    rsp_next.rdata  = read_mem(pend_addr);
                end
            end
            rsp_next.gnt = (gnt_left == 0) && (!pending || rsp_next.rvalid);  // back to back ok
        end
    end

    always @(posedge clk) begin
        mem_rsp <= rsp_next;
        if (reset) begin
            cycle <= 0;
            stall <= 1'b0;
        end else begin
            cycle <= cycle + 1;
            stall <= in_window(cycle + 1);
        end
    end

    // decoded_o moves only on edges without stall
    always @(negedge clk) begin
        if (!reset) begin
            if (stall_seen) begin
                checks++;
                assert (decoded === prev_dec) else begin
                    errors++;
                    $display("[FAIL] %0t decoded_o changed during stall", $time);
                end
            end else if (decoded.valid) begin
                check_retire();
            end
        end
        prev_dec   = decoded;
        stall_seen = stall;
    end

    initial begin
        int unsigned assert_fails;
        load_stim();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        wait (retired == exp_pc.size());
        @(posedge clk);
        assert_fails = u_dut.u_ins_fetch.u_fetch_assert.fail_count;
        $display("retired %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
                 retired, exp_pc.size(), checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (reset_cycles + cycles_per_instr * exp_pc.size() + stall_total) @(posedge clk);
        $display("timeout, only %0d of %0d words retired", retired, exp_pc.size());
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
